/* sim.f */
verilog/bdiLinePkg.sv
verilog/bdiCodecPkg.sv
verilog/baseDeltaScan.sv
verilog/bdiCompressor.sv
verilog/bdiDecompressor.sv
verilog/bdiTop.sv
tb/bdiTop_checker.sv
tb/bdiTb.sv

/* tb/bdiTb.sv */
`timescale 1ns/1ps

module bdiTb
    import bdiLinePkg::*;
    import bdiCodecPkg::*;
;

    localparam int ResetCycles = 16;
    localparam int EqualLines = 8;
    localparam int StructLines = 40;
    localparam int RandomLines = 40;
    localparam int MixedLines = 100;
    localparam int TotalLines = EqualLines + 4 * StructLines + RandomLines + MixedLines;
    localparam int TimeoutCycles = ResetCycles + TotalLines * 2 + 200;

    typedef struct packed
    {
        logic [31:0] stamp;
        compressedLineT comp;
        lineT line;
    } expectT;

    logic clock = 1'b0;
    logic rstN;
    lineT line;
    compressedLineT compressed;
    lineT rebuiltLine;

    logic [31:0] rngState = 32'h96684e37;
    logic [31:0] cycle = '0;
    expectT compQ [$];
    expectT lineQ [$];
    expectT compHead;
    expectT lineHead;
    int encSeen [8];
    int checkCount = 0;
    int errorCount = 0;

    bdiTop i_dut (
        .clock(clock),
        .rstN(rstN),
        .line(line),
        .compressed(compressed),
        .rebuiltLine(rebuiltLine)
    );

    always #4 clock = ~clock;

    always @(posedge clock)
    begin
        cycle <= cycle + 1;
        if (cycle >= TimeoutCycles)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [63:0] rand64();
        logic [63:0] value;
        value[31:0] = nextRand();
        value[63:32] = nextRand();
        return value;
    endfunction

    function automatic logic [63:0] widthMask(int bits);
        return (bits >= 64) ? '1 : ((64'd1 << bits) - 64'd1);
    endfunction

    function automatic logic [63:0] signExtend(logic [63:0] value, int bits);
        logic [63:0] result;
        result = value & widthMask(bits);
        if (bits < 64 && result[bits-1])
            result = result | ~widthMask(bits);
        return result;
    endfunction

    // Base plus small signed offsets or zero offsets when deltaBytes is 0
    function automatic lineT structuredLine(int elemBytes, int deltaBytes);
        lineT ln;
        logic [63:0] mask;
        logic [63:0] base;
        logic [63:0] elem;
        int elemBits;
        elemBits = elemBytes * 8;
        mask = widthMask(elemBits);
        base = rand64() & mask;
        ln = '0;
        for (int e = 0; e < LineBytes / elemBytes; e++)
        begin
            elem = base;
            if (e > 0 && deltaBytes > 0)
                elem = base + signExtend(rand64(), deltaBytes * 8);
            ln = ln | (lineT'(elem & mask) << (e * elemBits));
        end
        return ln;
    endfunction

    function automatic lineT buildLine(int category);
        lineT ln;
        logic [31:0] pick;
        case (category)
            0: ln = structuredLine(8, 0);
            1: ln = structuredLine(8, 1);
            2:
            begin
                pick = nextRand();
                ln = structuredLine(8, pick[0] ? 4 : 2);
            end
            3:
            begin
                pick = nextRand();
                ln = structuredLine(4, pick[0] ? 2 : 1);
            end
            4: ln = structuredLine(2, 1);
            default:
            begin
                for (int i = 0; i < LineBytes / 4; i++)
                    ln[i*32 +: 32] = nextRand();
            end
        endcase
        return ln;
    endfunction

    // Tries one base/delta size and returns whether every delta fits
    function automatic bit packLine(input lineT ln, input int elemBytes, input int deltaBytes,
                                    output lineT payload);
        int elemBits;
        int deltaBits;
        logic [63:0] mask;
        logic [63:0] base;
        logic [63:0] elem;
        logic [63:0] diff;
        bit fit;
        elemBits = elemBytes * 8;
        deltaBits = deltaBytes * 8;
        mask = widthMask(elemBits);
        base = ln[63:0] & mask;
        payload = lineT'(base);
        fit = 1'b1;
        for (int e = 1; e < LineBytes / elemBytes; e++)
        begin
            elem = 64'(ln >> (e * elemBits)) & mask;
            diff = (elem - base) & mask;
            if ((signExtend(diff, deltaBits) & mask) != diff)
                fit = 1'b0;
            payload = payload |
                (lineT'(diff & widthMask(deltaBits)) << (elemBits + (e - 1) * deltaBits));
        end
        return fit;
    endfunction

    function automatic compressedLineT modelCompress(lineT ln);
        compressedLineT result;
        lineT payload;
        int elemBytes;
        int deltaBytes;
        bit found;
        result.encoding = encNone;
        result.payload = ln;
        found = 1'b0;
        // Base 8 with deltas 1,2,4 then base 4 with 1,2 then base 2 with 1
        for (int k = 0; k < 6; k++)
        begin
            elemBytes = (k < 3) ? 8 : ((k < 5) ? 4 : 2);
            deltaBytes = (k < 3) ? (1 << k) : ((k < 5) ? (1 << (k - 3)) : 1);
            if (!found && packLine(ln, elemBytes, deltaBytes, payload))
            begin
                result.encoding = bdiEncodingT'(k);
                result.payload = payload;
                found = 1'b1;
            end
        end
        return result;
    endfunction

    task automatic checkValue(input logic [$bits(compressedLineT)-1:0] actual,
                              input logic [$bits(compressedLineT)-1:0] expected,
                              input string msg);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    task automatic driveLine(input lineT ln, input compressedLineT expected);
        expectT entry;
        @(posedge clock);
        line <= ln;
        entry.stamp = cycle;
        entry.comp = expected;
        entry.line = ln;
        compQ.push_back(entry);
        lineQ.push_back(entry);
        encSeen[expected.encoding]++;
    endtask

    task automatic drainPipeline();
        while (compQ.size() > 0 || lineQ.size() > 0)
            @(negedge clock);
    endtask

    task automatic reportTest(input string name, input int lines, input int errorsBefore);
        $display("%s: %0d lines, %0d errors", name, lines, errorCount - errorsBefore);
    endtask

    // Compressed shows after one edge and the rebuilt line after two
    always @(negedge clock)
    begin
        if (compQ.size() > 0 && compQ[0].stamp + 2 == cycle)
        begin
            compHead = compQ.pop_front();
            checkValue(compressed, compHead.comp, "compressed line");
        end
        if (lineQ.size() > 0 && lineQ[0].stamp + 3 == cycle)
        begin
            lineHead = lineQ.pop_front();
            checkValue(rebuiltLine, lineHead.line, "rebuilt line");
        end
    end

    initial
    begin
        int errorsBefore;
        lineT ln;
        rstN = 1'b0;
        line = '0;

        errorsBefore = errorCount;
        for (int i = 0; i < ResetCycles; i++)
        begin
            @(posedge clock);
            if (i == ResetCycles - 1)
                rstN <= 1'b1;
            @(negedge clock);
            checkValue(compressed, compressedLineT'{encoding: encNone, payload: '0},
                       "compressed in reset");
            checkValue(rebuiltLine, '0, "rebuilt line in reset");
        end
        @(negedge clock);
        checkValue(rebuiltLine, '0, "rebuilt line after reset");
        reportTest("reset", 0, errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < EqualLines; i++)
        begin
            ln = buildLine(0);
            driveLine(ln, '{encoding: encB8D1, payload: lineT'(ln[63:0])});
        end
        drainPipeline();
        reportTest("equal elements", EqualLines, errorsBefore);

        errorsBefore = errorCount;
        for (int c = 1; c < 5; c++)
        begin
            for (int i = 0; i < StructLines; i++)
            begin
                ln = buildLine(c);
                driveLine(ln, modelCompress(ln));
            end
        end
        drainPipeline();
        reportTest("structured lines", 4 * StructLines, errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < RandomLines; i++)
        begin
            ln = buildLine(5);
            driveLine(ln, '{encoding: encNone, payload: ln});
        end
        drainPipeline();
        reportTest("random lines", RandomLines, errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < MixedLines; i++)
        begin
            ln = buildLine(nextRand() % 6);
            driveLine(ln, modelCompress(ln));
        end
        drainPipeline();
        reportTest("back to back mixed", MixedLines, errorsBefore);

        for (int k = 0; k < 7; k++)
        begin
            if (encSeen[k] == 0)
            begin
                errorCount++;
                $display("Coverage error: encoding %0d was never exercised", k);
            end
        end

        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* tb/bdiTop_checker.sv */
`timescale 1ns/1ps

module bdiTop_checker
    import bdiLinePkg::*;
    import bdiCodecPkg::*;
(
    input logic clock,
    input logic rstN,
    input lineT line,
    input compressedLineT compressed,
    input lineT rebuiltLine
);

    // Both stages out of reset, so the round trip is complete
    roundTrip: assert property (@(posedge clock)
        $past(rstN) && $past(rstN, 2) |-> rebuiltLine == $past(line, 2))
        else $error("rebuilt line differs from the line sent two cycles earlier");

    rawPayload: assert property (@(posedge clock)
        $past(rstN) && compressed.encoding == encNone |-> compressed.payload == $past(line))
        else $error("uncompressed payload differs from the line sent one cycle earlier");

    legalEncoding: assert property (@(posedge clock)
        rstN |-> compressed.encoding inside {encB8D1, encB8D2, encB8D4, encB4D1,
                                             encB4D2, encB2D1, encNone})
        else $error("encoding holds an undefined value");

endmodule

bind bdiTop bdiTop_checker i_checker (
    .clock(clock),
    .rstN(rstN),
    .line(line),
    .compressed(compressed),
    .rebuiltLine(rebuiltLine)
);

/* verilog/baseDeltaScan.sv */
`timescale 1ns/1ps

module baseDeltaScan
    import bdiLinePkg::*;
    import bdiCodecPkg::*;
#(
    parameter int ElemBytes = 8
)
(
    input  lineT line,
    output deltaFitT fits,
    output logic [(LineBytes/ElemBytes-1)*ElemBytes*ByteBits-1:0] deltas
);

    localparam int ElemBits = ElemBytes * ByteBits;
    localparam int NumElems = LineBytes / ElemBytes;

    logic [NumElems-1:0][ElemBits-1:0] elems;
    logic [NumElems-2:0][ElemBits-1:0] deltaArr;

    assign elems = line;
    assign deltas = deltaArr;

    // Difference against element 0, wraps at the element width
    for (genvar e = 1; e < NumElems; e++)
    begin : gDelta
        assign deltaArr[e-1] = elems[e] - elems[0];
    end

    for (genvar w = 0; w < 3; w++)
    begin : gFit
        localparam int DeltaBits = ByteBits << w;

        if (DeltaBits < ElemBits)
        begin : gCheck
            logic [NumElems-2:0] elemFits;

            for (genvar e = 0; e < NumElems - 1; e++)
            begin : gElem
                logic [ElemBits-DeltaBits:0] upper;

                // Sign bit of the short delta and everything above it
                assign upper = deltaArr[e][ElemBits-1:DeltaBits-1];
                assign elemFits[e] = (&upper) | (~|upper);
            end

            assign fits[w] = &elemFits;
        end
        else
        begin : gWide
            // A delta as wide as the element saves nothing
            assign fits[w] = 1'b0;
        end
    end

endmodule

/* verilog/bdiCodecPkg.sv */
package bdiCodecPkg;

    import bdiLinePkg::*;

    // Listed in selection priority, first match wins
    typedef enum logic [2:0]
    {
        encB8D1,
        encB8D2,
        encB8D4,
        encB4D1,
        encB4D2,
        encB2D1,
        encNone
    } bdiEncodingT;

    // Bit 0 for 1-byte deltas, bit 1 for 2-byte, bit 2 for 4-byte
    typedef logic [2:0] deltaFitT;

    // Payload is base, then deltas of elements 1..N-1, zero above
    typedef struct packed
    {
        bdiEncodingT encoding;
        lineT payload;
    } compressedLineT;

endpackage

/* verilog/bdiCompressor.sv */
`timescale 1ns/1ps

module bdiCompressor
    import bdiLinePkg::*;
    import bdiCodecPkg::*;
#(
    parameter int Elem8 = 8,
    parameter int Elem4 = 4,
    parameter int Elem2 = 2
)
(
    input  logic clock,
    input  logic rstN,
    input  lineT line,
    output compressedLineT compressed
);

    localparam int ElemSizes [3] = '{Elem8, Elem4, Elem2};

    deltaFitT scanFits [3];
    lineT packedLines [3][3];
    bdiEncodingT encoding;
    lineT payload;
    compressedLineT nextCompressed;

    for (genvar s = 0; s < 3; s++)
    begin : gScan
        localparam int ElemBytes = ElemSizes[s];
        localparam int ElemBits = ElemBytes * ByteBits;
        localparam int NumElems = LineBytes / ElemBytes;

        logic [(NumElems-1)*ElemBits-1:0] deltas;

        baseDeltaScan #(
            .ElemBytes(ElemBytes)
        ) i_scan (
            .line(line),
            .fits(scanFits[s]),
            .deltas(deltas)
        );

        // One packed candidate per usable delta width
        for (genvar w = 0; w < 3; w++)
        begin : gPack
            localparam int DeltaBits = ByteBits << w;

            if (DeltaBits < ElemBits)
            begin : gPacked
                lineT packedLine;

                always_comb
                begin
                    packedLine = '0;
                    packedLine[ElemBits-1:0] = line[ElemBits-1:0];
                    for (int e = 0; e < NumElems - 1; e++)
                    begin
                        packedLine[ElemBits + e*DeltaBits +: DeltaBits] =
                            deltas[e*ElemBits +: DeltaBits];
                    end
                end

                assign packedLines[s][w] = packedLine;
            end
            else
            begin : gUnused
                assign packedLines[s][w] = '0;
            end
        end
    end

    // Largest base and smallest delta win
    always_comb
    begin
        if (scanFits[0][0])
            encoding = encB8D1;
        else if (scanFits[0][1])
            encoding = encB8D2;
        else if (scanFits[0][2])
            encoding = encB8D4;
        else if (scanFits[1][0])
            encoding = encB4D1;
        else if (scanFits[1][1])
            encoding = encB4D2;
        else if (scanFits[2][0])
            encoding = encB2D1;
        else
            encoding = encNone;
    end

    always_comb
    begin
        case (encoding)
            encB8D1: payload = packedLines[0][0];
            encB8D2: payload = packedLines[0][1];
            encB8D4: payload = packedLines[0][2];
            encB4D1: payload = packedLines[1][0];
            encB4D2: payload = packedLines[1][1];
            encB2D1: payload = packedLines[2][0];
            default: payload = line;
        endcase
    end

    always_comb
    begin
        nextCompressed.encoding = encoding;
        nextCompressed.payload = payload;
    end

    always_ff @(posedge clock)
    begin
        if (!rstN)
            compressed <= '{encoding: encNone, payload: '0};
        else
            compressed <= nextCompressed;
    end

endmodule

/* verilog/bdiDecompressor.sv */
`timescale 1ns/1ps

module bdiDecompressor
    import bdiLinePkg::*;
    import bdiCodecPkg::*;
(
    input  logic clock,
    input  logic rstN,
    input  compressedLineT compressed,
    output lineT rebuiltLine
);

    // Element sizes named by the encodings
    localparam int ElemSizes [3] = '{8, 4, 2};

    lineT payload;
    lineT candidates [3][3];
    lineT nextLine;

    assign payload = compressed.payload;

    for (genvar s = 0; s < 3; s++)
    begin : gSize
        localparam int ElemBits = ElemSizes[s] * ByteBits;
        localparam int NumElems = LineBits / ElemBits;

        for (genvar w = 0; w < 3; w++)
        begin : gWidth
            localparam int DeltaBits = ByteBits << w;

            if (DeltaBits < ElemBits)
            begin : gRebuild
                logic [ElemBits-1:0] base;
                lineT rebuilt;

                assign base = payload[ElemBits-1:0];
                assign rebuilt[ElemBits-1:0] = base;

                for (genvar e = 1; e < NumElems; e++)
                begin : gElem
                    logic [DeltaBits-1:0] delta;

                    assign delta = payload[ElemBits + (e-1)*DeltaBits +: DeltaBits];
                    // Sign-extend, then add back modulo the element width
                    assign rebuilt[e*ElemBits +: ElemBits] =
                        base + {{(ElemBits-DeltaBits){delta[DeltaBits-1]}}, delta};
                end

                assign candidates[s][w] = rebuilt;
            end
            else
            begin : gUnused
                assign candidates[s][w] = '0;
            end
        end
    end

    always_comb
    begin
        case (compressed.encoding)
            encB8D1: nextLine = candidates[0][0];
            encB8D2: nextLine = candidates[0][1];
            encB8D4: nextLine = candidates[0][2];
            encB4D1: nextLine = candidates[1][0];
            encB4D2: nextLine = candidates[1][1];
            encB2D1: nextLine = candidates[2][0];
            // Raw line travels as is
            default: nextLine = payload;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (!rstN)
            rebuiltLine <= '0;
        else
            rebuiltLine <= nextLine;
    end

endmodule

/* verilog/bdiLinePkg.sv */
package bdiLinePkg;

    // Line geometry
    localparam int ByteBits = 8;
    localparam int LineBytes = 32;
    localparam int LineBits = LineBytes * ByteBits;

    // Element 0 sits in the lowest bits
    typedef logic [LineBits-1:0] lineT;

endpackage

/* verilog/bdiTop.sv */
`timescale 1ns/1ps

module bdiTop
    import bdiLinePkg::*;
    import bdiCodecPkg::*;
(
    input  logic clock,
    input  logic rstN,
    input  lineT line,
    output compressedLineT compressed,
    output lineT rebuiltLine
);

    // Compressed line feeds both the output and the decompressor
    compressedLineT compressedLine;

    assign compressed = compressedLine;

    bdiCompressor #(
        .Elem8(8),
        .Elem4(4),
        .Elem2(2)
    ) i_compressor (
        .clock(clock),
        .rstN(rstN),
        .line(line),
        .compressed(compressedLine)
    );

    bdiDecompressor i_decompressor (
        .clock(clock),
        .rstN(rstN),
        .compressed(compressedLine),
        .rebuiltLine(rebuiltLine)
    );

endmodule
